// File: logic/net_perf_pkg.sv
package net_perf_pkg;

	////////////////////////////////////////
	// Sizing

	// Ports served by the block
	localparam int NUM_PORTS     = 4;
	localparam int PORT_BITS     = 2;

	// One beat is four bytes wide
	localparam int DATA_WIDTH    = 32;

	// Byte count runs 1..4, so one bit more than log2 of bytes per beat
	localparam int BYTE_CNT_BITS = $clog2(DATA_WIDTH / 8) + 1;

	localparam int COUNT_WIDTH   = 32;
	localparam int REGID_BITS    = 4;

	// PHY held in reset this many cycles after system reset
	localparam int PHY_RST_CYCLES = 64;

	////////////////////////////////////////
	// Register map and FSM states

	// Ids outside this set read back as zero
	typedef enum logic [REGID_BITS-1:0] {
		REG_RX_FRAMES = 4'd0,
		REG_RX_BYTES  = 4'd1,
		REG_RX_DROPS  = 4'd2,
		REG_TX_FRAMES = 4'd3,
		REG_TX_BYTES  = 4'd4
	} perf_reg_t;

	typedef enum logic [1:0] {
		IDLE,
		ISSUE,
		WAIT,
		HOLD
	} rd_state_t;

	// Five counters of one port, 160 bits
	typedef struct packed {
		logic [COUNT_WIDTH-1:0] rx_frames;
		logic [COUNT_WIDTH-1:0] rx_bytes;
		logic [COUNT_WIDTH-1:0] rx_drops;
		logic [COUNT_WIDTH-1:0] tx_frames;
		logic [COUNT_WIDTH-1:0] tx_bytes;
	} port_counters_t;

endpackage

// File: logic/mac_bus_if.sv
`timescale 1ns/1ps

// One direction of a MAC bus, as seen by the statistics logic
interface mac_bus_if import net_perf_pkg::*; ();

	// First beat of a frame
	logic                     start;
	logic                     valid;
	// Valid bytes in this beat, 1..4
	logic [BYTE_CNT_BITS-1:0] bytes;
	// End of frame, good or discarded
	logic                     commit;
	logic                     drop;

	// Statistics side only listens
	modport counter (input start, valid, bytes, commit, drop);

	// MAC side
	modport source (output start, valid, bytes, commit, drop);

endinterface

// File: logic/perf_read_if.sv
`timescale 1ns/1ps

// Read path from the host controller into the counter readout mux
interface perf_read_if import net_perf_pkg::*; ();

	// Request, single cycle pulse
	logic                   rd_en;
	logic [PORT_BITS-1:0]   port;
	logic [REGID_BITS-1:0]  regid;

	// Response, two cycles after rd_en
	logic                   rd_valid;
	logic [COUNT_WIDTH-1:0] rd_data;

	modport ctrl (output rd_en, port, regid, input rd_valid, rd_data);

	modport mux (input rd_en, port, regid, output rd_valid, rd_data);

endinterface

// File: logic/phy_reset_seq.sv
`timescale 1ns/1ps

module phy_reset_seq import net_perf_pkg::*; (
	input  logic clk_125mhz,
	input  logic reset,
	output logic phy_rst_n
);

	// Cycles elapsed since system reset went away
	logic [$clog2(PHY_RST_CYCLES)-1:0] count;

	always_ff @(posedge clk_125mhz) begin
		if (reset) begin
			count     <= '0;
			phy_rst_n <= 1'b0;
		end
		else if (!phy_rst_n) begin
			count <= count + 1'b1;

			// Release on the last counted edge, then stay put
			if (count == ($clog2(PHY_RST_CYCLES))'(PHY_RST_CYCLES - 1))
				phy_rst_n <= 1'b1;
		end
	end

endmodule

// File: logic/mac_perf_counters.sv
`timescale 1ns/1ps

module mac_perf_counters import net_perf_pkg::*; (
	input  logic           clk_125mhz,
	input  logic           reset,

	mac_bus_if.counter     rx,
	mac_bus_if.counter     tx,

	// Zero this port's counters
	input  logic           clear,

	output port_counters_t counters
);

	////////////////////////////////////////
	// Per-beat increments

	// Frame ends, sampled with valid
	logic rx_good;
	logic rx_bad;
	logic tx_good;

	// Beat sizes widened to counter width
	logic [COUNT_WIDTH-1:0] rx_beat_bytes;
	logic [COUNT_WIDTH-1:0] tx_beat_bytes;

	assign rx_good = rx.valid && rx.commit;
	assign rx_bad  = rx.valid && rx.drop;
	assign tx_good = tx.valid && tx.commit;

	// Dropped frames still moved bytes on the wire
	assign rx_beat_bytes = rx.valid ? COUNT_WIDTH'(rx.bytes) : '0;
	assign tx_beat_bytes = tx.valid ? COUNT_WIDTH'(tx.bytes) : '0;

	////////////////////////////////////////
	// Counter registers

	// start needs no handling, the first beat counts like any other
	// TX drop is not tracked, only its bytes
	always_ff @(posedge clk_125mhz) begin
		if (reset || clear) begin
			counters <= '0;
		end
		else begin
			// Receive side
			counters.rx_bytes <= counters.rx_bytes + rx_beat_bytes;
			if (rx_good)
				counters.rx_frames <= counters.rx_frames + 1'b1;
			if (rx_bad)
				counters.rx_drops <= counters.rx_drops + 1'b1;

			// Transmit side
			counters.tx_bytes <= counters.tx_bytes + tx_beat_bytes;
			if (tx_good)
				counters.tx_frames <= counters.tx_frames + 1'b1;
		end
	end

endmodule

// File: logic/perf_readout_mux.sv
`timescale 1ns/1ps

module perf_readout_mux import net_perf_pkg::*; (
	input  logic                             clk_125mhz,
	input  logic                             reset,

	// Live counters of every port
	input  port_counters_t [NUM_PORTS-1:0]   counters,

	perf_read_if.mux                         rd
);

	////////////////////////////////////////
	// Stage one, port select

	logic                  s1_valid;
	port_counters_t        s1_counters;
	logic [REGID_BITS-1:0] s1_regid;

	always_ff @(posedge clk_125mhz) begin
		if (reset)
			s1_valid <= 1'b0;
		else
			s1_valid <= rd.rd_en;
	end

	// Snapshot of the whole port, field picked next cycle
	always_ff @(posedge clk_125mhz) begin
		s1_counters <= counters[rd.port];
		s1_regid    <= rd.regid;
	end

	////////////////////////////////////////
	// Stage two, register select

	always_ff @(posedge clk_125mhz) begin
		if (reset)
			rd.rd_valid <= 1'b0;
		else
			rd.rd_valid <= s1_valid;
	end

	always_ff @(posedge clk_125mhz) begin
		case (s1_regid)
			REG_RX_FRAMES: rd.rd_data <= s1_counters.rx_frames;
			REG_RX_BYTES:  rd.rd_data <= s1_counters.rx_bytes;
			REG_RX_DROPS:  rd.rd_data <= s1_counters.rx_drops;
			REG_TX_FRAMES: rd.rd_data <= s1_counters.tx_frames;
			REG_TX_BYTES:  rd.rd_data <= s1_counters.tx_bytes;
			// Unmapped ids
			default:       rd.rd_data <= '0;
		endcase
	end

endmodule

// File: logic/perf_read_ctrl.sv
`timescale 1ns/1ps

module perf_read_ctrl import net_perf_pkg::*; (
	input  logic                   clk_125mhz,
	input  logic                   reset,

	// Host side, four-phase handshake
	input  logic                   perf_req,
	input  logic [PORT_BITS-1:0]   perf_port,
	input  logic [REGID_BITS-1:0]  perf_regid,
	output logic                   perf_ack,
	output logic [COUNT_WIDTH-1:0] perf_value,

	perf_read_if.ctrl              rd
);

	rd_state_t state;

	// One cycle read strobe into the mux
	assign rd.rd_en = (state == ISSUE);

	// Ack held for as long as the host keeps req up
	assign perf_ack = (state == HOLD);

	////////////////////////////////////////
	// Handshake FSM

	always_ff @(posedge clk_125mhz) begin
		if (reset) begin
			state <= IDLE;
		end
		else begin
			case (state)
				IDLE:  if (perf_req) state <= ISSUE;
				ISSUE: state <= WAIT;
				WAIT:  if (rd.rd_valid) state <= HOLD;
				HOLD:  if (!perf_req) state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	// Request captured once, host keeps it stable anyway
	always_ff @(posedge clk_125mhz) begin
		if ((state == IDLE) && perf_req) begin
			rd.port  <= perf_port;
			rd.regid <= perf_regid;
		end
	end

	// Result stays put through HOLD and after
	always_ff @(posedge clk_125mhz) begin
		if ((state == WAIT) && rd.rd_valid)
			perf_value <= rd.rd_data;
	end

endmodule

// File: logic/net_perf_top.sv
`timescale 1ns/1ps

module net_perf_top import net_perf_pkg::*; (
	input  logic                                      clk_125mhz,
	input  logic                                      reset,

	// Receive MAC buses
	input  logic [NUM_PORTS-1:0]                      rx_start,
	input  logic [NUM_PORTS-1:0]                      rx_valid,
	input  logic [NUM_PORTS-1:0][BYTE_CNT_BITS-1:0]   rx_bytes,
	input  logic [NUM_PORTS-1:0]                      rx_commit,
	input  logic [NUM_PORTS-1:0]                      rx_drop,

	// Transmit MAC buses
	input  logic [NUM_PORTS-1:0]                      tx_start,
	input  logic [NUM_PORTS-1:0]                      tx_valid,
	input  logic [NUM_PORTS-1:0][BYTE_CNT_BITS-1:0]   tx_bytes,
	input  logic [NUM_PORTS-1:0]                      tx_commit,
	input  logic [NUM_PORTS-1:0]                      tx_drop,

	// Host counter access
	input  logic [NUM_PORTS-1:0]                      perf_rst,
	input  logic                                      perf_req,
	input  logic [PORT_BITS-1:0]                      perf_port,
	input  logic [REGID_BITS-1:0]                     perf_regid,
	output logic                                      perf_ack,
	output logic [COUNT_WIDTH-1:0]                    perf_value,

	output logic                                      phy_rst_n
);

	////////////////////////////////////////
	// PHY reset

	phy_reset_seq phy_rst (
		.clk_125mhz (clk_125mhz),
		.reset      (reset),
		.phy_rst_n  (phy_rst_n)
	);

	////////////////////////////////////////
	// Per-port counters

	port_counters_t [NUM_PORTS-1:0] port_counters;

	for (genvar g = 0; g < NUM_PORTS; g++) begin : ports
		mac_bus_if rx_bus ();
		mac_bus_if tx_bus ();

		// Flat top-level pins onto the bus bundles
		assign rx_bus.start  = rx_start[g];
		assign rx_bus.valid  = rx_valid[g];
		assign rx_bus.bytes  = rx_bytes[g];
		assign rx_bus.commit = rx_commit[g];
		assign rx_bus.drop   = rx_drop[g];

		assign tx_bus.start  = tx_start[g];
		assign tx_bus.valid  = tx_valid[g];
		assign tx_bus.bytes  = tx_bytes[g];
		assign tx_bus.commit = tx_commit[g];
		assign tx_bus.drop   = tx_drop[g];

		mac_perf_counters count (
			.clk_125mhz (clk_125mhz),
			.reset      (reset),
			.rx         (rx_bus),
			.tx         (tx_bus),
			.clear      (perf_rst[g]),
			.counters   (port_counters[g])
		);
	end

	////////////////////////////////////////
	// Readout path

	perf_read_if rd_bus ();

	perf_readout_mux readout (
		.clk_125mhz (clk_125mhz),
		.reset      (reset),
		.counters   (port_counters),
		.rd         (rd_bus)
	);

	// Host handshake, issues one read per request
	perf_read_ctrl read_ctrl (
		.clk_125mhz (clk_125mhz),
		.reset      (reset),
		.perf_req   (perf_req),
		.perf_port  (perf_port),
		.perf_regid (perf_regid),
		.perf_ack   (perf_ack),
		.perf_value (perf_value),
		.rd         (rd_bus)
	);

endmodule

// File: tests/net_perf_tb.sv
`timescale 1ns/1ps

module net_perf_tb import net_perf_pkg::*; ();

	logic clk_125mhz;
	logic reset;

	// Index 0 is the receive bus and index 1 the transmit bus
	logic [1:0][NUM_PORTS-1:0]                    bus_start;
	logic [1:0][NUM_PORTS-1:0]                    bus_valid;
	logic [1:0][NUM_PORTS-1:0][BYTE_CNT_BITS-1:0] bus_bytes;
	logic [1:0][NUM_PORTS-1:0]                    bus_commit;
	logic [1:0][NUM_PORTS-1:0]                    bus_drop;
	logic [NUM_PORTS-1:0]                         perf_rst;
	logic                                         perf_req;
	logic [PORT_BITS-1:0]                         perf_port;
	logic [REGID_BITS-1:0]                        perf_regid;
	logic                                         perf_ack;
	logic [COUNT_WIDTH-1:0]                       perf_value;
	logic                                         phy_rst_n;

	// Parsed command codes (FRAME 0, CLEAR 1, READ 2, PHYCHK 3)
	int               vec_code[$];
	logic [3:0][31:0] vec_args[$];
	int               errors = 0;
	int               checks = 0;
	int               cycles = 0;
	int               limit = 0;
	int unsigned      seed;

	net_perf_top dut (
		.*,
		.rx_start  (bus_start[0]),
		.rx_valid  (bus_valid[0]),
		.rx_bytes  (bus_bytes[0]),
		.rx_commit (bus_commit[0]),
		.rx_drop   (bus_drop[0]),
		.tx_start  (bus_start[1]),
		.tx_valid  (bus_valid[1]),
		.tx_bytes  (bus_bytes[1]),
		.tx_commit (bus_commit[1]),
		.tx_drop   (bus_drop[1])
	);

	always #4 clk_125mhz = ~clk_125mhz;

	// Run limit armed once the vectors are loaded
	always @(posedge clk_125mhz) begin
		cycles++;
		if (limit > 0 && cycles > limit) begin
			$display("Timeout, run still busy after %0d cycles", limit);
			$display("Run stopped, %0d checks, %0d errors", checks, errors);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	////////////////////////////////////////
	// Checking helpers

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			$display("ERR %s: got %h, expected %h", name, actual, expected);
			errors++;
		end
	endtask

	task automatic flag_error(input string msg);
		$display("%s", msg);
		errors++;
	endtask

	////////////////////////////////////////
	// Bus and host drivers

	// Full beats of four bytes with the remainder in the last one
	task automatic send_frame(input logic [PORT_BITS-1:0] p, input logic d, input int total,
		input logic drop);
		int left;
		int n;
		left = total;
		while (left > 0) begin
			n = (left > DATA_WIDTH / 8) ? DATA_WIDTH / 8 : left;
			@(negedge clk_125mhz);
			bus_valid[d][p]  = 1'b1;
			bus_bytes[d][p]  = BYTE_CNT_BITS'(n);
			bus_start[d][p]  = (left == total);
			bus_commit[d][p] = (left == n) && !drop;
			bus_drop[d][p]   = (left == n) && drop;
			left -= n;
		end
		@(negedge clk_125mhz);
		bus_valid  = '0;
		bus_start  = '0;
		bus_commit = '0;
		bus_drop   = '0;
		// Idle gap 0..3 cycles
		repeat ($urandom % 4) @(negedge clk_125mhz);
	endtask

	task automatic clear_port(input logic [PORT_BITS-1:0] p);
		@(negedge clk_125mhz);
		perf_rst[p] = 1'b1;
		@(negedge clk_125mhz);
		perf_rst[p] = 1'b0;
	endtask

	task automatic do_read(input logic [PORT_BITS-1:0] p, input logic [REGID_BITS-1:0] regid,
		input logic [COUNT_WIDTH-1:0] expected);
		// Traffic quiet for two cycles first
		repeat (2) @(negedge clk_125mhz);
		perf_port  = p;
		perf_regid = regid;
		perf_req   = 1'b1;
		// Ack stays low after edges n to n+2
		repeat (3) begin
			@(negedge clk_125mhz);
			if (perf_ack)
				flag_error("perf_ack rose before the third edge after req");
		end
		@(negedge clk_125mhz);
		if (!perf_ack)
			flag_error("perf_ack did not rise three edges after req");
		check_value("perf_value", perf_value, expected);
		// Host stalls with req still high
		repeat ($urandom % 4) begin
			@(negedge clk_125mhz);
			if (!perf_ack)
				flag_error("perf_ack fell while perf_req was still high");
			check_value("perf_value", perf_value, expected);
		end
		perf_req = 1'b0;
		@(negedge clk_125mhz);
		if (perf_ack)
			flag_error("perf_ack did not fall at the first edge with perf_req low");
	endtask

	////////////////////////////////////////
	// Vector file

	task automatic load_vectors();
		int fd;
		int code;
		int budget;
		int unsigned a;
		int unsigned b;
		int unsigned c;
		int unsigned d;
		logic [63:0] word;
		logic [8*128-1:0] rest;
		budget = PHY_RST_CYCLES;
		fd = $fopen("tests/perf_vectors.txt", "r");
		if (fd == 0) begin
			flag_error("cannot open tests/perf_vectors.txt");
		end
		else begin
			while ($fscanf(fd, "%s", word) == 1) begin
				if (word == 64'("#")) begin
					code = $fgets(rest, fd);
				end
				else if (word == 64'("FRAME")) begin
					code = $fscanf(fd, "%d %d %d %d", a, b, c, d);
					vec_code.push_back(0);
					budget += int'((c + 3) / 4) + 3;
				end
				else if (word == 64'("CLEAR")) begin
					code = $fscanf(fd, "%d", a);
					vec_code.push_back(1);
					budget += 2;
				end
				else if (word == 64'("READ")) begin
					code = $fscanf(fd, "%d %d %h", a, b, c);
					vec_code.push_back(2);
					budget += 8;
				end
				else if (word == 64'("PHYCHK")) begin
					vec_code.push_back(3);
					budget += 1;
				end
				else begin
					flag_error("unknown command in tests/perf_vectors.txt");
				end
				// One argument set per command
				if (vec_args.size() < vec_code.size())
					vec_args.push_back({d, c, b, a});
			end
			$fclose(fd);
		end
		limit = 2 * budget;
	endtask

	initial begin
		clk_125mhz = 1'b0;
		reset      = 1'b1;
		bus_start  = '0;
		bus_valid  = '0;
		bus_bytes  = '0;
		bus_commit = '0;
		bus_drop   = '0;
		perf_rst   = '0;
		perf_req   = 1'b0;
		perf_port  = '0;
		perf_regid = '0;
		seed = $urandom(32'h6828_19db);
		load_vectors();

		// PHY reset low through reset and PHY_RST_CYCLES edges after
		repeat (2) @(negedge clk_125mhz);
		reset = 1'b0;
		repeat (PHY_RST_CYCLES) begin
			check_value("phy_rst_n", 32'(phy_rst_n), 32'd0);
			@(negedge clk_125mhz);
		end
		check_value("phy_rst_n", 32'(phy_rst_n), 32'd1);

		foreach (vec_code[i]) begin
			case (vec_code[i])
				0: send_frame(PORT_BITS'(vec_args[i][0]), vec_args[i][1][0],
					vec_args[i][2], vec_args[i][3][0]);
				1: clear_port(PORT_BITS'(vec_args[i][0]));
				2: do_read(PORT_BITS'(vec_args[i][0]), REGID_BITS'(vec_args[i][1]),
					vec_args[i][2]);
				default: check_value("phy_rst_n", 32'(phy_rst_n), 32'd1);
			endcase
		end

		repeat (2) @(negedge clk_125mhz);
		$display("Run complete, %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// File: tests/perf_vectors.txt
# FRAME port dir(0 rx, 1 tx) bytes end(0 commit, 1 drop)   CLEAR port
# READ port regid expected(hex)   PHYCHK expects the PHY reset released
PHYCHK
FRAME 0 0 64 0
FRAME 2 1 1500 0
FRAME 0 0 10 0
FRAME 1 0 7 1
FRAME 0 1 60 0
FRAME 3 1 8 1
FRAME 2 1 3 0
READ 0 0 2
READ 0 1 4a
READ 0 2 0
READ 0 3 1
READ 0 4 3c
READ 1 0 0
READ 1 1 7
READ 1 2 1
READ 1 4 0
READ 2 3 2
READ 2 4 5df
READ 3 3 0
READ 3 4 8
READ 0 5 0
READ 2 15 0
CLEAR 0
READ 0 0 0
READ 0 1 0
READ 1 1 7
FRAME 0 0 5 0
READ 0 0 1
READ 0 1 5
PHYCHK

// File: net_perf_top.f
logic/net_perf_pkg.sv
logic/mac_bus_if.sv
logic/perf_read_if.sv
logic/phy_reset_seq.sv
logic/mac_perf_counters.sv
logic/perf_readout_mux.sv
logic/perf_read_ctrl.sv
logic/net_perf_top.sv
tests/net_perf_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing -f net_perf_top.f --top-module net_perf_tb -o net_perf_sim
./obj_dir/net_perf_sim | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
	exit 1
fi
